//--- vlog.f
common/ttc_pkg.sv
src/ttc_trig_counters.sv
trigger/ttc_trigger_fsm.sv
trigger/ddr3_occupancy.sv
src/ttc_trigger_top.sv
tb/ttc_trigger_sva.sv
tb/ttc_trigger_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the trigger testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module ttc_trigger_tb -Mdir obj_dir &&
./obj_dir/Vttc_trigger_tb | tee /dev/stderr | grep -q "all tests passed" &&
echo "simulation PASSED" ||
{ echo "simulation FAILED"; exit 1; }

//--- tb/ttc_trigger_tb.sv
// trigger subsystem testbench

`timescale 1ns/100ps

module ttc_trigger_tb
  import ttc_pkg::*;
;

  localparam int timeout_cycles = 3000;  // about 80 triggers at worst back-pressure

  logic                      clk = 1'b0;
  logic                      reset, reset_trig_num, reset_trig_timestamp;
  logic                      trigger, readout_done, acq_ready, acq_activated;
  logic                      async_mode, fifo_ready;
  trig_type_t                trig_type;
  logic [31:0]               trig_settings;
  logic [num_chan-1:0]       chan_en;
  chan_cfg_t [num_chan-1:0]  chan_cfg;
  burst_cnt_t                thres_ddr3_overflow;
  logic [3:0]                xadc_alarms;
  acq_cmd_t                  acq;
  logic                      fifo_valid, ddr3_almost_full, error_trig_rate;
  trig_record_t              fifo_data, held;
  fsm_state_t                state;
  trig_num_t                 trig_num;
  timestamp_t                trig_timestamp;
  burst_cnt_t [num_chan-1:0] stored_bursts;
  logic [31:0]               ddr3_overflow_count;

  // reference model state
  integer       seed = 32'h8a58_c45f;
  trig_num_t    m_trig_num = 24'd1;
  trig_num_t    m_event_num = 24'd1;
  timestamp_t   m_ts;
  burst_cnt_t   m_bursts [num_chan];
  logic [31:0]  m_overflow = '0;
  int           sent = 0;
  int           done = 0;
  int           cycles = 0;
  logic         hold_low = 1'b0;
  trig_record_t rec_q [$];
  acq_cmd_t     acq_q [$];

  ttc_trigger_top dut0 (.*);

  initial forever #50 clk = ~clk;

  always @(posedge clk) m_ts <= (reset || reset_trig_timestamp) ? '0 : m_ts + 1'b1;

  // random fifo back-pressure
  always @(negedge clk) fifo_ready = !hold_low && (($random(seed) & 3) != 0);

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles == timeout_cycles) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("tests failed");
      $fatal(1);
    end
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_record(input trig_record_t got, input trig_record_t exp);
    if (got !== exp) begin
      $display("FAIL time=%0t fifo_data got=%h exp=%h", $time, got, exp);
      stop_run("fifo record mismatch");
    end
  endtask

  task automatic check_acq(input acq_cmd_t got, input acq_cmd_t exp);
    if (got !== exp) begin
      $display("FAIL time=%0t acq got=%h exp=%h", $time, got, exp);
      stop_run("acquisition command mismatch");
    end
  endtask

  task automatic check_bursts(input int ch, input burst_cnt_t got, input burst_cnt_t exp);
    if (got !== exp) begin
      $display("FAIL time=%0t stored_bursts[%0d] got=%h exp=%h", $time, ch, got, exp);
      stop_run("occupancy mismatch");
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%h exp=%h", $time, name, got, exp);
      stop_run("counter mismatch");
    end
  endtask

  task automatic check_num(input trig_num_t got, input trig_num_t exp);
    if (got !== exp) begin
      $display("FAIL time=%0t trig_num got=%h exp=%h", $time, got, exp);
      stop_run("trigger number mismatch");
    end
  endtask

  task automatic check_stamp(input timestamp_t got, input timestamp_t exp);
    if (got !== exp) begin
      $display("FAIL time=%0t trig_timestamp got=%h exp=%h", $time, got, exp);
      stop_run("timestamp mismatch");
    end
  endtask

  task automatic check_state(input fsm_state_t got, input fsm_state_t exp);
    if (got !== exp) begin
      $display("FAIL time=%0t state got=%h exp=%h", $time, got, exp);
      stop_run("state mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%b exp=%b", $time, name, got, exp);
      stop_run("status flag mismatch");
    end
  endtask

  function automatic longint acq_size(input int i);
    return (longint'(chan_cfg[i].burst_count) + 1) * longint'(chan_cfg[i].wfm_count) + 2;
  endfunction

  function automatic logic is_full();
    logic full;
    full = 1'b0;
    for (int i = 0; i < num_chan; i++) begin
      if (chan_en[i] && (longint'(ddr3_depth) - longint'(m_bursts[i]) < acq_size(i))) begin
        full = 1'b1;
      end
    end
    return full;
  endfunction

  // record the fifo should receive for a trigger latched now
  function automatic trig_record_t expected_record(input trig_type_t t, input logic [3:0] al,
                                                   input timestamp_t ts);
    trig_record_t r;
    r = '0;
    if (async_mode) begin
      r.empty_event = (t != async_trig_type) || !acq_activated;
    end else begin
      r.empty_event = !trig_settings[t] || is_full();
    end
    r.xadc_alarms = al;
    r.trig_type   = t;
    r.event_num   = m_event_num;
    r.trig_num    = m_trig_num;
    r.timestamp   = ts;
    return r;
  endfunction

  // compare process
  always @(posedge clk) begin
    if (!reset && fifo_valid && fifo_ready) begin
      if (rec_q.size() == 0) begin
        stop_run("fifo transfer with no trigger pending");
      end else begin
        check_record(fifo_data, rec_q.pop_front());
        done = done + 1;
      end
    end
    if (!reset && acq.trigger) begin
      if (acq_q.size() == 0) begin
        stop_run("acquisition trigger without an accepted trigger");
      end else begin
        check_acq(acq, acq_q.pop_front());
      end
    end
  end

  task automatic send_trig(input trig_type_t t, input bit modeled);
    trig_record_t r;
    logic         want;
    @(negedge clk);
    trigger     = 1'b1;
    trig_type   = t;
    xadc_alarms = 4'($random(seed));
    if (modeled) begin
      r    = expected_record(t, xadc_alarms, m_ts);
      want = !r.empty_event && acq_ready;
      if (acq_ready) begin
        rec_q.push_back(r);
        sent = sent + 1;
      end
      if (want) begin
        acq_q.push_back('{1'b1, t, m_trig_num});
        m_event_num = m_event_num + 1'b1;
        for (int i = 0; i < num_chan; i++) begin
          if (chan_en[i] && !async_mode) m_bursts[i] = m_bursts[i] + burst_cnt_t'(acq_size(i));
        end
      end
      if (acq_ready && r.empty_event && !async_mode && trig_settings[t]) begin
        m_overflow = m_overflow + 1;  // refused for lack of ddr3 space
      end
      m_trig_num = m_trig_num + 1'b1;
    end
    @(negedge clk);
    trigger = 1'b0;
    if (modeled) begin
      check_state(state, send_trigger);
      check_stamp(trig_timestamp, r.timestamp);  // latched with the trigger
      @(negedge clk);
      check_flag("acq.trigger", acq.trigger, want);
      check_count("ddr3_overflow_count", ddr3_overflow_count, m_overflow);
      check_state(state, acq_ready ? store_trig_info : error);
    end
  endtask

  task automatic check_occupancy();
    logic want;
    want = 1'b0;
    for (int i = 0; i < num_chan; i++) begin
      check_bursts(i, stored_bursts[i], m_bursts[i]);
      if (m_bursts[i] > thres_ddr3_overflow) want = 1'b1;
    end
    check_flag("ddr3_almost_full", ddr3_almost_full, want);
  endtask

  task automatic finish_record();
    while (done < sent) @(negedge clk);
    check_state(state, idle);
    check_occupancy();
    repeat ($unsigned($random(seed)) % 4) @(negedge clk);  // random gap
  endtask

  task automatic run_trig(input trig_type_t t);
    send_trig(t, 1'b1);
    finish_record();
  endtask

  task automatic readout();
    @(negedge clk);
    readout_done = 1'b1;
    for (int i = 0; i < num_chan; i++) begin
      if (chan_en[i]) m_bursts[i] = m_bursts[i] - chan_cfg[i].readout_size;
    end
    @(negedge clk);
    readout_done = 1'b0;
    check_occupancy();
  endtask

  initial begin
    trig_type_t t;
    reset = 1'b1;
    reset_trig_num = 1'b0;
    reset_trig_timestamp = 1'b0;
    trigger = 1'b0;
    trig_type = '0;
    trig_settings = ~32'h4;  // type 2 blocked
    chan_en = 5'b10111;
    for (int i = 0; i < num_chan; i++) begin
      chan_cfg[i].burst_count  = burst_cnt_t'(i + 1);
      chan_cfg[i].wfm_count    = 12'd3;
      chan_cfg[i].readout_size = burst_cnt_t'((i + 2) * 3 + 2);  // one acquisition
      m_bursts[i] = '0;
    end
    thres_ddr3_overflow = 23'd40;
    readout_done = 1'b0;
    acq_ready = 1'b1;
    acq_activated = 1'b0;
    async_mode = 1'b0;
    xadc_alarms = '0;
    fifo_ready = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk) reset = 1'b0;

    // accepted and blocked types, then readouts
    repeat (4) begin
      t = 5'($random(seed));
      if (t == 5'd2) t = 5'd3;
      run_trig(t);
    end
    run_trig(5'd2);
    run_trig(5'd2);
    repeat (3) readout();

    // back-pressure holds the record, extra triggers dropped
    hold_low = 1'b1;
    send_trig(5'd1, 1'b1);
    while (!fifo_valid) @(negedge clk);
    held = fifo_data;
    send_trig(5'd4, 1'b0);
    repeat (5) begin
      @(negedge clk);
      check_record(fifo_data, held);
    end
    check_num(trig_num, m_trig_num);
    hold_low = 1'b0;
    finish_record();

    // ddr3 overflow on the fourth large acquisition
    @(negedge clk) async_mode = 1'b1;
    @(negedge clk) async_mode = 1'b0;
    for (int i = 0; i < num_chan; i++) begin
      m_bursts[i] = '0;
      chan_cfg[i].burst_count  = burst_cnt_t'((1 << 21) - 1);
      chan_cfg[i].wfm_count    = 12'd1;
      chan_cfg[i].readout_size = '0;
    end
    repeat (4) run_trig(5'd1);

    // asynchronous mode with a numbering restart
    @(negedge clk) async_mode = 1'b1;
    for (int i = 0; i < num_chan; i++) m_bursts[i] = '0;
    @(negedge clk);
    reset_trig_num       = 1'b1;  // both channel b resets
    reset_trig_timestamp = 1'b1;
    @(negedge clk);
    reset_trig_num       = 1'b0;
    reset_trig_timestamp = 1'b0;
    m_trig_num  = 24'd1;
    m_event_num = 24'd1;
    run_trig(5'd7);
    acq_activated = 1'b1;
    run_trig(5'd7);
    run_trig(5'd3);

    // channels not ready, error is sticky
    @(negedge clk) async_mode = 1'b0;
    acq_ready = 1'b0;
    send_trig(5'd1, 1'b1);
    acq_ready = 1'b1;
    repeat (3) @(negedge clk);
    check_flag("error_trig_rate", error_trig_rate, 1'b1);
    send_trig(5'd1, 1'b0);
    repeat (10) @(negedge clk);
    check_flag("error_trig_rate", error_trig_rate, 1'b1);
    check_flag("fifo_valid", fifo_valid, 1'b0);
    check_state(state, error);

    if (rec_q.size() == 0 && acq_q.size() == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("expected records or commands never arrived");
      $display("tests failed");
      $fatal(1);
    end
  end

endmodule

//--- tb/ttc_trigger_sva.sv
// trigger fsm assertions

`timescale 1ns/100ps

module ttc_trigger_sva
  import ttc_pkg::*;
(
  input logic         clk,
  input logic         reset,
  input fsm_state_t   state,
  input acq_cmd_t     acq,
  input logic         fifo_valid,
  input logic         fifo_ready,
  input trig_record_t fifo_data
);

  state_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(state))
    else $error("state not one-hot");

  acq_pulse: assert property (@(posedge clk) disable iff (reset) acq.trigger |=> !acq.trigger)
    else $error("acq.trigger longer than one cycle");

  // word held while the fifo stalls
  data_hold: assert property (@(posedge clk) disable iff (reset)
    fifo_valid && !fifo_ready |=> fifo_valid && $stable(fifo_data))
    else $error("fifo_data changed under back-pressure");

  error_sticky: assert property (@(posedge clk) disable iff (reset)
    state == error |=> state == error)
    else $error("error state exited");

endmodule

bind ttc_trigger_fsm ttc_trigger_sva sva0 (.*);

//--- src/ttc_trigger_top.sv
// ttc trigger receiver top level

`timescale 1ns/100ps

module ttc_trigger_top
  import ttc_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      reset_trig_num,
  input  logic                      reset_trig_timestamp,
  input  logic                      trigger,
  input  trig_type_t                trig_type,
  input  logic [31:0]               trig_settings,
  input  logic [num_chan-1:0]       chan_en,
  input  chan_cfg_t [num_chan-1:0]  chan_cfg,
  input  burst_cnt_t                thres_ddr3_overflow,
  input  logic                      readout_done,
  input  logic                      acq_ready,
  input  logic                      acq_activated,
  input  logic                      async_mode,
  input  logic [3:0]                xadc_alarms,
  input  logic                      fifo_ready,
  output acq_cmd_t                  acq,
  output logic                      fifo_valid,
  output trig_record_t              fifo_data,
  output fsm_state_t                state,
  output trig_num_t                 trig_num,
  output timestamp_t                trig_timestamp,
  output burst_cnt_t [num_chan-1:0] stored_bursts,
  output logic [31:0]               ddr3_overflow_count,
  output logic                      ddr3_almost_full,
  output logic                      error_trig_rate
);

  timestamp_t timestamp_cnt;
  trig_num_t  next_trig_num;
  trig_num_t  next_event_num;
  logic       trig_take;
  logic       ddr3_full;

  ttc_trig_counters counters0 (
    .clk                  (clk),
    .reset                (reset),
    .reset_trig_num       (reset_trig_num),
    .reset_trig_timestamp (reset_trig_timestamp),
    .trig_take            (trig_take),
    .acq_trigger          (acq.trigger),
    .timestamp_cnt        (timestamp_cnt),
    .next_trig_num        (next_trig_num),
    .next_event_num       (next_event_num)
  );

  ddr3_occupancy occupancy0 (
    .clk                 (clk),
    .reset               (reset),
    .async_mode          (async_mode),
    .chan_en             (chan_en),
    .chan_cfg            (chan_cfg),
    .thres_ddr3_overflow (thres_ddr3_overflow),
    .acq_trigger         (acq.trigger),
    .readout_done        (readout_done),
    .stored_bursts       (stored_bursts),
    .ddr3_full           (ddr3_full),
    .ddr3_almost_full    (ddr3_almost_full)
  );

  ttc_trigger_fsm fsm0 (
    .clk                 (clk),
    .reset               (reset),
    .trigger             (trigger),
    .trig_type           (trig_type),
    .trig_settings       (trig_settings),
    .async_mode          (async_mode),
    .acq_ready           (acq_ready),
    .acq_activated       (acq_activated),
    .xadc_alarms         (xadc_alarms),
    .ddr3_full           (ddr3_full),
    .timestamp_cnt       (timestamp_cnt),
    .next_trig_num       (next_trig_num),
    .next_event_num      (next_event_num),
    .fifo_ready          (fifo_ready),
    .trig_take           (trig_take),
    .acq                 (acq),
    .fifo_valid          (fifo_valid),
    .fifo_data           (fifo_data),
    .state               (state),
    .trig_num            (trig_num),
    .trig_timestamp      (trig_timestamp),
    .ddr3_overflow_count (ddr3_overflow_count),
    .error_trig_rate     (error_trig_rate)
  );

endmodule

//--- trigger/ddr3_occupancy.sv
// ddr3 burst occupancy per channel

`timescale 1ns/100ps

module ddr3_occupancy
  import ttc_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       async_mode,   // counts held at zero
  input  logic [num_chan-1:0]        chan_en,
  input  chan_cfg_t [num_chan-1:0]   chan_cfg,
  input  burst_cnt_t                 thres_ddr3_overflow,
  input  logic                       acq_trigger,  // one acquisition started
  input  logic                       readout_done, // one readout finished
  output burst_cnt_t [num_chan-1:0]  stored_bursts,
  output logic                       ddr3_full,
  output logic                       ddr3_almost_full
);

  burst_cnt_t [num_chan-1:0] acq_size;   // bursts written by one acquisition
  burst_cnt_t [num_chan-1:0] add_size;
  burst_cnt_t [num_chan-1:0] sub_size;
  logic [burst_w:0]          free_space [num_chan];
  logic [num_chan-1:0]       chan_full;
  logic [num_chan-1:0]       chan_warn;

  always_comb begin
    for (int i = 0; i < num_chan; i++) begin
      // (burst_count + 1) bursts per waveform, plus two header bursts
      acq_size[i] = (chan_cfg[i].burst_count + 23'd1) *
                    burst_cnt_t'(chan_cfg[i].wfm_count) + 23'd2;

      if (acq_trigger && chan_en[i]) begin
        add_size[i] = acq_size[i];
      end else begin
        add_size[i] = '0;
      end

      if (readout_done && chan_en[i]) begin
        sub_size[i] = chan_cfg[i].readout_size;
      end else begin
        sub_size[i] = '0;
      end

      free_space[i] = (burst_w + 1)'(ddr3_depth) - {1'b0, stored_bursts[i]};
      // next acquisition would overwrite unread data
      chan_full[i]  = chan_en[i] && (free_space[i] < {1'b0, acq_size[i]});
      chan_warn[i]  = stored_bursts[i] > thres_ddr3_overflow;
    end
  end

  assign ddr3_full        = |chan_full;
  assign ddr3_almost_full = |chan_warn;

  // add and remove in the same cycle when both strobes coincide
  always_ff @(posedge clk) begin
    if (reset || async_mode) begin
      stored_bursts <= '0;
    end else begin
      for (int i = 0; i < num_chan; i++) begin
        stored_bursts[i] <= stored_bursts[i] + add_size[i] - sub_size[i];
      end
    end
  end

endmodule

//--- trigger/ttc_trigger_fsm.sv
// trigger handling state machine

`timescale 1ns/100ps

module ttc_trigger_fsm
  import ttc_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         trigger,        // ttc trigger strobe
  input  trig_type_t   trig_type,
  input  logic [31:0]  trig_settings,  // 1 = pass type, 0 = block
  input  logic         async_mode,
  input  logic         acq_ready,
  input  logic         acq_activated,
  input  logic [3:0]   xadc_alarms,
  input  logic         ddr3_full,
  input  timestamp_t   timestamp_cnt,
  input  trig_num_t    next_trig_num,
  input  trig_num_t    next_event_num,
  input  logic         fifo_ready,
  output logic         trig_take,
  output acq_cmd_t     acq,
  output logic         fifo_valid,
  output trig_record_t fifo_data,
  output fsm_state_t   state,
  output trig_num_t    trig_num,
  output timestamp_t   trig_timestamp,
  output logic [31:0]  ddr3_overflow_count,
  output logic         error_trig_rate
);

  fsm_state_t  next_state;
  logic        empty_event;  // record goes out without an acquisition
  logic        empty_now;
  logic        accept;
  logic        overflow;
  logic        load_record;
  logic [3:0]  lat_alarms;

  // empty decision for the trigger arriving now
  always_comb begin
    if (async_mode) begin
      empty_now = (trig_type != async_trig_type) || !acq_activated;
    end else begin
      empty_now = !trig_settings[trig_type] || ddr3_full;
    end
  end

  always_comb begin
    next_state = state;
    trig_take  = 1'b0;
    accept     = 1'b0;
    overflow   = 1'b0;
    case (state)
      idle: begin
        if (trigger) begin
          trig_take  = 1'b1;
          next_state = send_trigger;
        end
      end
      send_trigger: begin
        if (!acq_ready) begin
          next_state = error;  // channels still busy with the last trigger
        end else begin
          accept     = !empty_event;
          // enabled type but refused, so the ddr3 was full
          overflow   = empty_event && !async_mode && trig_settings[acq.trig_type];
          next_state = store_trig_info;
        end
      end
      store_trig_info: begin
        if (fifo_ready) begin
          next_state = idle;
        end
      end
      error: begin
        next_state = error;  // only reset leaves
      end
      default: begin
        next_state = idle;
      end
    endcase
  end

  assign load_record = (state == send_trigger) && (next_state == store_trig_info);

  always_ff @(posedge clk) begin
    if (reset) begin
      state               <= idle;
      acq.trigger         <= 1'b0;
      fifo_valid          <= 1'b0;
      empty_event         <= 1'b0;
      ddr3_overflow_count <= '0;
    end else begin
      state       <= next_state;
      acq.trigger <= accept;  // single-cycle pulse
      if (trig_take) begin
        empty_event <= empty_now;
      end
      if (overflow) begin
        ddr3_overflow_count <= ddr3_overflow_count + 32'd1;
      end
      if (load_record) begin
        fifo_valid <= 1'b1;
      end else if (state == store_trig_info && fifo_ready) begin
        fifo_valid <= 1'b0;  // word taken by the fifo
      end
    end

    // trigger details, captured on entry to send_trigger
    if (trig_take) begin
      acq.trig_type  <= trig_type;
      acq.trig_num   <= next_trig_num;
      trig_timestamp <= timestamp_cnt;
      lat_alarms     <= xadc_alarms;
    end

    // held until the fifo accepts it
    if (load_record) begin
      fifo_data <= '{
        spare:       '0,
        xadc_alarms: lat_alarms,
        empty_event: empty_event,
        trig_type:   acq.trig_type,
        event_num:   next_event_num,
        trig_num:    acq.trig_num,
        timestamp:   trig_timestamp
      };
    end
  end

  assign trig_num        = next_trig_num;
  assign error_trig_rate = (state == error);  // sticky

endmodule

//--- src/ttc_trig_counters.sv
// trigger number and timestamp counters

`timescale 1ns/100ps

module ttc_trig_counters
  import ttc_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       reset_trig_num,        // channel b command
  input  logic       reset_trig_timestamp,  // channel b command
  input  logic       trig_take,             // trigger latched by the fsm
  input  logic       acq_trigger,           // trigger passed to the channels
  output timestamp_t timestamp_cnt,
  output trig_num_t  next_trig_num,
  output trig_num_t  next_event_num
);

  // free-running clock count
  always_ff @(posedge clk) begin
    if (reset || reset_trig_timestamp) begin
      timestamp_cnt <= '0;
    end else begin
      timestamp_cnt <= timestamp_cnt + 1'b1;
    end
  end

  // global trigger number, every received trigger
  always_ff @(posedge clk) begin
    if (reset || reset_trig_num) begin
      next_trig_num <= trig_num_t'(1);  // numbering starts at 1
    end else if (trig_take) begin
      next_trig_num <= next_trig_num + 1'b1;
    end
  end

  // event number, only triggers the channels acquired
  always_ff @(posedge clk) begin
    if (reset || reset_trig_num) begin
      next_event_num <= trig_num_t'(1);
    end else if (acq_trigger) begin
      next_event_num <= next_event_num + 1'b1;
    end
  end

endmodule

//--- common/ttc_pkg.sv
// trigger subsystem shared types

package ttc_pkg;

  // digitizer geometry
  localparam int num_chan = 5;                   // channels per digitizer
  localparam int unsigned ddr3_depth = 1 << 23;  // bursts per channel

  // field widths
  localparam int burst_w    = 23;
  localparam int trig_num_w = 24;
  localparam int ts_w       = 44;
  localparam int type_w     = 5;
  localparam int wfm_w      = 12;
  localparam int alarm_w    = 4;
  localparam int spare_w    = 26;  // pads the fifo word to 128 bits

  typedef logic [burst_w-1:0]    burst_cnt_t;
  typedef logic [trig_num_w-1:0] trig_num_t;
  typedef logic [ts_w-1:0]       timestamp_t;
  typedef logic [type_w-1:0]     trig_type_t;

  // asynchronous readout trigger
  localparam trig_type_t async_trig_type = 5'd7;

  // one-hot state encoding
  typedef enum logic [3:0] {
    idle            = 4'b0001,
    send_trigger    = 4'b0010,
    store_trig_info = 4'b0100,
    error           = 4'b1000
  } fsm_state_t;

  // per-channel acquisition settings
  typedef struct packed {
    burst_cnt_t         burst_count;   // bursts per waveform, minus one
    logic [wfm_w-1:0]   wfm_count;     // waveforms per acquisition
    burst_cnt_t         readout_size;  // bursts freed by one readout
  } chan_cfg_t;

  // command to the channel acquisition controller
  typedef struct packed {
    logic       trigger;
    trig_type_t trig_type;
    trig_num_t  trig_num;
  } acq_cmd_t;

  // 128-bit word for the trigger fifo, msb first
  typedef struct packed {
    logic [spare_w-1:0] spare;
    logic [alarm_w-1:0] xadc_alarms;
    logic               empty_event;
    trig_type_t         trig_type;
    trig_num_t          event_num;
    trig_num_t          trig_num;
    timestamp_t         timestamp;
  } trig_record_t;

endpackage
